// File: files.f
rtl/matmul_pkg.sv
rtl/mem_port_if.sv
rtl/row_buffer.sv
rtl/skew_feeder.sv
rtl/mac_pe.sv
rtl/systolic_array.sv
rtl/matmul_ctrl.sv
rtl/matmul_top.sv
verification/matmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module matmul_tb \
  -f files.f -o matmul_sim \
  && ./obj_dir/matmul_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// File: verification/matmul_tb.sv
module matmul_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N           = matmul_pkg::ARRAY_SIZE;
  localparam int DEPTH       = matmul_pkg::MEM_DEPTH;
  localparam int HOLD        = 4;
  localparam int NUM_CASES   = 7;
  localparam int DONE_LIMIT  = DEPTH + 64;
  localparam int LOAD_CYCLES = 2 * DEPTH * HOLD;
  localparam int DRAIN       = 2 * (N - 1) + 1 + N;
  localparam int READ_CYCLES = N * HOLD;
  localparam int WATCHDOG_NS =
    NUM_CASES * (LOAD_CYCLES + 128 + DRAIN + READ_CYCLES) * 10 * 2;

  typedef enum logic [1:0] {
    PAT_RANDOM,
    PAT_IDENTITY,
    PAT_MAX
  } pattern_t;

  typedef struct packed {
    matmul_pkg::addr_t inner_last;
    pattern_t          pattern;
    logic              extra_start;
  } case_t;

  // inner_last, operand pattern, second start while busy
  localparam case_t CASES [NUM_CASES] = '{
    '{7'd3,  PAT_IDENTITY, 1'b0},
    '{7'd0,  PAT_RANDOM,   1'b0},
    '{7'd3,  PAT_RANDOM,   1'b0},
    '{7'd36, PAT_RANDOM,   1'b0},
    '{7'd15, PAT_MAX,      1'b0},
    '{7'd3,  PAT_RANDOM,   1'b1},
    '{7'd36, PAT_RANDOM,   1'b0}
  };

  logic              clk;
  logic              reset;
  logic              mem_write_en;
  logic              mem_read_en;
  matmul_pkg::addr_t addr;
  matmul_pkg::row_t  wdata;
  logic              we_a;
  logic              we_b;
  matmul_pkg::row_t  rdata;
  logic              start;
  matmul_pkg::addr_t inner_last;
  logic              done;

  // A kept as [row][k], B as [k][col]
  matmul_pkg::elem_t a_mat [N][DEPTH];
  matmul_pkg::elem_t b_mat [DEPTH][N];

  int seed;
  int errors;
  int checks;
  int job_k;

  matmul_top matmul_top_inst (
    .clk          (clk),
    .reset        (reset),
    .mem_write_en (mem_write_en),
    .mem_read_en  (mem_read_en),
    .addr         (addr),
    .wdata        (wdata),
    .we_a         (we_a),
    .we_b         (we_b),
    .rdata        (rdata),
    .start        (start),
    .inner_last   (inner_last),
    .done         (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////
  // Operands and model
  //////////////////////////////
  task automatic fill_operands(input pattern_t pat, input int k);
    for (int w = 0; w < k; w++) begin
      for (int i = 0; i < N; i++) begin
        case (pat)
          PAT_MAX: begin
            a_mat[i][w] = 16'hffff;
            b_mat[w][i] = 16'hffff;
          end
          PAT_IDENTITY: begin
            a_mat[i][w] = matmul_pkg::elem_t'($random(seed));
            b_mat[w][i] = (w == i) ? 16'd1 : 16'd0;
          end
          default: begin
            a_mat[i][w] = matmul_pkg::elem_t'($random(seed));
            b_mat[w][i] = matmul_pkg::elem_t'($random(seed));
          end
        endcase
      end
    end
  endtask

  // Sum of products, wrapping at 16 bits
  function automatic matmul_pkg::elem_t model_elem(input int i, input int j, input int k);
    matmul_pkg::elem_t sum;
    sum = '0;
    for (int s = 0; s < k; s++) begin
      sum = sum + a_mat[i][s] * b_mat[s][j];
    end
    return sum;
  endfunction

  //////////////////////////////
  // Host port sequences
  //////////////////////////////
  task automatic write_word(input logic to_b, input matmul_pkg::addr_t a,
                            input matmul_pkg::row_t d);
    mem_write_en = 1'b1;
    addr         = a;
    wdata        = d;
    we_a         = !to_b;
    we_b         = to_b;
    repeat (HOLD) @(posedge clk);
    #1;
  endtask

  task automatic load_operands(input int k);
    matmul_pkg::row_t row;
    for (int w = 0; w < k; w++) begin
      for (int lane = 0; lane < N; lane++) begin
        row[lane] = a_mat[lane][w];
      end
      write_word(1'b0, matmul_pkg::addr_t'(w), row);
      for (int lane = 0; lane < N; lane++) begin
        row[lane] = b_mat[w][lane];
      end
      write_word(1'b1, matmul_pkg::addr_t'(w), row);
    end
    mem_write_en = 1'b0;
    we_a         = 1'b0;
    we_b         = 1'b0;
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic run_job(input matmul_pkg::addr_t last, input logic extra);
    int cycles;
    int drops;
    inner_last = last;
    start      = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    checks++;
    assert (done == 1'b0) else begin
      errors++;
      $display("Mismatch at %0t: done still high after an accepted start", $time);
    end
    // This start lands while the engine is busy
    if (extra) begin
      repeat (3) @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    cycles = 0;
    while (!done && cycles < DONE_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    checks++;
    assert (done) else begin
      errors++;
      $display("Error at %0t: done did not rise within %0d cycles", $time, DONE_LIMIT);
    end
    // A queued second job would pull done low again
    drops = 0;
    repeat (16) begin
      @(posedge clk);
      #1;
      if (!done) drops++;
    end
    checks++;
    assert (drops == 0) else begin
      errors++;
      $display("Mismatch at %0t: done fell in %0d cycles after rising", $time, drops);
    end
  endtask

  task automatic read_check(input int idx, input int k);
    matmul_pkg::row_t  got;
    matmul_pkg::elem_t exp_val;
    mem_read_en = 1'b1;
    for (int r = 0; r < N; r++) begin
      addr = matmul_pkg::addr_t'(r);
      repeat (HOLD) @(posedge clk);
      #1;
      got = rdata;
      for (int j = 0; j < N; j++) begin
        exp_val = model_elem(r, j, k);
        checks++;
        assert (got[j] == exp_val) else begin
          errors++;
          $display("Mismatch at %0t: case %0d C[%0d][%0d] = %h, expected %h",
                   $time, idx, r, j, got[j], exp_val);
        end
      end
    end
    mem_read_en = 1'b0;
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    seed         = 32'hbff2d3f8;
    errors       = 0;
    checks       = 0;
    reset        = 1'b1;
    mem_write_en = 1'b0;
    mem_read_en  = 1'b0;
    addr         = '0;
    wdata        = '0;
    we_a         = 1'b0;
    we_b         = 1'b0;
    start        = 1'b0;
    inner_last   = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle after reset, no job yet
    repeat (8) begin
      @(posedge clk);
      #1;
      checks++;
      assert (done == 1'b0) else begin
        errors++;
        $display("Mismatch at %0t: done high before any start", $time);
      end
    end

    for (int t = 0; t < NUM_CASES; t++) begin
      job_k = int'(CASES[t].inner_last) + 1;
      fill_operands(CASES[t].pattern, job_k);
      load_operands(job_k);
      run_job(CASES[t].inner_last, CASES[t].extra_start);
      read_check(t, job_k);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: rtl/matmul_top.sv
module matmul_top #(
  parameter int SIZE  = matmul_pkg::ARRAY_SIZE,
  parameter int DEPTH = matmul_pkg::MEM_DEPTH
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_write_en,
  input  logic              mem_read_en,
  input  matmul_pkg::addr_t addr,
  input  matmul_pkg::row_t  wdata,
  input  logic              we_a,
  input  logic              we_b,
  output matmul_pkg::row_t  rdata,
  input  logic              start,
  input  matmul_pkg::addr_t inner_last,
  output logic              done
);

  mem_port_if a_port ();
  mem_port_if b_port ();
  mem_port_if c_port ();

  matmul_pkg::row_t a_fed;
  matmul_pkg::row_t b_fed;
  matmul_pkg::row_t acc_rows [SIZE];
  logic             feed_valid;
  logic             clear_acc;

  //////////////////////////////
  // Operand and result memories
  //////////////////////////////
  // Word k of A holds column k, word k of B holds row k
  row_buffer #(.DEPTH(DEPTH)) a_buf (
    .clk        (clk),
    .reset      (reset),
    .host_sel   (mem_write_en),
    .host_addr  (addr),
    .host_wdata (wdata),
    .host_we    (we_a),
    .eng        (a_port.buffer),
    .host_rdata ()
  );

  row_buffer #(.DEPTH(DEPTH)) b_buf (
    .clk        (clk),
    .reset      (reset),
    .host_sel   (mem_write_en),
    .host_addr  (addr),
    .host_wdata (wdata),
    .host_we    (we_b),
    .eng        (b_port.buffer),
    .host_rdata ()
  );

  // Host only reads C
  row_buffer #(.DEPTH(DEPTH)) c_buf (
    .clk        (clk),
    .reset      (reset),
    .host_sel   (mem_read_en),
    .host_addr  (addr),
    .host_wdata ('0),
    .host_we    (1'b0),
    .eng        (c_port.buffer),
    .host_rdata (rdata)
  );

  //////////////////////////////
  // Skew and compute
  //////////////////////////////
  skew_feeder #(.LANES(SIZE)) a_feeder (
    .clk      (clk),
    .reset    (reset),
    .in_row   (a_port.rdata),
    .in_valid (feed_valid),
    .out_row  (a_fed)
  );

  skew_feeder #(.LANES(SIZE)) b_feeder (
    .clk      (clk),
    .reset    (reset),
    .in_row   (b_port.rdata),
    .in_valid (feed_valid),
    .out_row  (b_fed)
  );

  systolic_array #(.SIZE(SIZE)) array_inst (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear_acc),
    .a_col    (a_fed),
    .b_row    (b_fed),
    .acc_rows (acc_rows)
  );

  matmul_ctrl #(.SIZE(SIZE)) ctrl_inst (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .inner_last (inner_last),
    .a_mem      (a_port.engine),
    .b_mem      (b_port.engine),
    .c_mem      (c_port.engine),
    .acc_rows   (acc_rows),
    .feed_valid (feed_valid),
    .clear_acc  (clear_acc),
    .done       (done)
  );

endmodule

// File: rtl/matmul_ctrl.sv
module matmul_ctrl #(
  parameter int SIZE = matmul_pkg::ARRAY_SIZE
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  matmul_pkg::addr_t inner_last,
  mem_port_if.engine        a_mem,
  mem_port_if.engine        b_mem,
  mem_port_if.engine        c_mem,
  input  matmul_pkg::row_t  acc_rows [SIZE],
  output logic              feed_valid,
  output logic              clear_acc,
  output logic              done
);

  // Last operand needs two full diagonals plus one cycle to settle
  localparam int DRAIN_CYCLES = 2 * (SIZE - 1) + 1;
  localparam int DRAIN_W      = $clog2(DRAIN_CYCLES + 1);
  localparam int ROW_W        = (SIZE > 1) ? $clog2(SIZE) : 1;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FEED,
    ST_DRAIN,
    ST_WRITE,
    ST_FINISHED
  } state_t;

  state_t            state;
  matmul_pkg::addr_t feed_cnt;
  matmul_pkg::addr_t inner_last_q;
  logic [DRAIN_W-1:0] drain_cnt;
  logic [ROW_W-1:0]  row_cnt;
  logic              accept;
  logic              last_row;

  // Start only counts while at rest
  assign accept   = start && (state == ST_IDLE || state == ST_FINISHED);
  assign last_row = (state == ST_WRITE) && (row_cnt == ROW_W'(SIZE - 1));

  //////////////////////////////
  // Phase sequencing
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      feed_cnt     <= '0;
      inner_last_q <= '0;
      drain_cnt    <= '0;
      row_cnt      <= '0;
    end else begin
      case (state)
        ST_IDLE, ST_FINISHED: begin
          if (accept) begin
            state        <= ST_FEED;
            feed_cnt     <= '0;
            inner_last_q <= inner_last;
          end
        end
        ST_FEED: begin
          if (feed_cnt == inner_last_q) begin
            state     <= ST_DRAIN;
            drain_cnt <= '0;
          end else begin
            feed_cnt <= feed_cnt + 1'b1;
          end
        end
        ST_DRAIN: begin
          if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) begin
            state   <= ST_WRITE;
            row_cnt <= '0;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        ST_WRITE: begin
          if (last_row) begin
            state <= ST_FINISHED;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Valid lags the address by the memory read cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      feed_valid <= 1'b0;
      clear_acc  <= 1'b0;
      done       <= 1'b0;
    end else begin
      feed_valid <= (state == ST_FEED);
      clear_acc  <= accept;
      if (accept) begin
        done <= 1'b0;
      end else if (last_row) begin
        done <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Memory requests
  //////////////////////////////
  // Operand memories are only read by the engine
  assign a_mem.addr  = feed_cnt;
  assign a_mem.wdata = '0;
  assign a_mem.we    = 1'b0;
  assign b_mem.addr  = feed_cnt;
  assign b_mem.wdata = '0;
  assign b_mem.we    = 1'b0;

  // One C row per cycle, row r to address r
  assign c_mem.addr  = matmul_pkg::addr_t'(row_cnt);
  assign c_mem.wdata = acc_rows[row_cnt];
  assign c_mem.we    = (state == ST_WRITE);

endmodule

// File: rtl/systolic_array.sv
module systolic_array #(
  parameter int SIZE = matmul_pkg::ARRAY_SIZE
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  matmul_pkg::row_t      a_col,
  input  matmul_pkg::row_t      b_row,
  output wire matmul_pkg::row_t acc_rows [SIZE]
);

  // A flows along rows, B flows down columns
  // Index 0 is the array edge fed from outside
  wire matmul_pkg::elem_t a_link [SIZE][SIZE+1];
  wire matmul_pkg::elem_t b_link [SIZE+1][SIZE];

  for (genvar r = 0; r < SIZE; r++) begin : g_a_edge
    assign a_link[r][0] = a_col[r];
  end

  for (genvar c = 0; c < SIZE; c++) begin : g_b_edge
    assign b_link[0][c] = b_row[c];
  end

  for (genvar r = 0; r < SIZE; r++) begin : g_row
    for (genvar c = 0; c < SIZE; c++) begin : g_col
      mac_pe pe_inst (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .a_in  (a_link[r][c]),
        .b_in  (b_link[r][c]),
        .a_out (a_link[r][c+1]),
        .b_out (b_link[r+1][c]),
        .acc   (acc_rows[r][c])
      );
    end
  end

endmodule

// File: rtl/mac_pe.sv
module mac_pe (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::elem_t a_in,
  input  matmul_pkg::elem_t b_in,
  output matmul_pkg::elem_t a_out,
  output matmul_pkg::elem_t b_out,
  output matmul_pkg::elem_t acc
);

  matmul_pkg::elem_t product;

  // Low half of the product only, sums wrap modulo 2^16
  assign product = a_in * b_in;

  // Operands move one cell right and one cell down per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      a_out <= '0;
      b_out <= '0;
    end else begin
      a_out <= a_in;
      b_out <= b_in;
    end
  end

  // Clear wins over accumulation
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else begin
      acc <= acc + product;
    end
  end

endmodule

// File: rtl/skew_feeder.sv
module skew_feeder #(
  parameter int LANES = matmul_pkg::ARRAY_SIZE
) (
  input  logic                  clk,
  input  logic                  reset,
  input  matmul_pkg::row_t      in_row,
  input  logic                  in_valid,
  output wire matmul_pkg::row_t out_row
);

  for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
    if (lane == 0) begin : g_direct
      // Lane 0 enters the array without delay
      assign out_row[lane] = in_valid ? in_row[lane] : '0;
    end else begin : g_delay
      matmul_pkg::elem_t data_pipe [lane];
      logic              valid_pipe [lane];

      always_ff @(posedge clk) begin
        data_pipe[0] <= in_row[lane];
        for (int s = 1; s < lane; s++) begin
          data_pipe[s] <= data_pipe[s-1];
        end
      end

      // Valid travels alongside the data of this lane
      always_ff @(posedge clk) begin
        if (reset) begin
          for (int s = 0; s < lane; s++) begin
            valid_pipe[s] <= 1'b0;
          end
        end else begin
          valid_pipe[0] <= in_valid;
          for (int s = 1; s < lane; s++) begin
            valid_pipe[s] <= valid_pipe[s-1];
          end
        end
      end

      // Idle slots feed zeros so nothing leaks into the sums
      assign out_row[lane] = valid_pipe[lane-1] ? data_pipe[lane-1] : '0;
    end
  end

endmodule

// File: rtl/row_buffer.sv
module row_buffer #(
  parameter int DEPTH = matmul_pkg::MEM_DEPTH
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              host_sel,
  input  matmul_pkg::addr_t host_addr,
  input  matmul_pkg::row_t  host_wdata,
  input  logic              host_we,
  mem_port_if.buffer        eng,
  output matmul_pkg::row_t  host_rdata
);

  logic              host_sel_q;
  logic              host_we_q;
  matmul_pkg::addr_t host_addr_q;
  matmul_pkg::row_t  host_wdata_q;

  matmul_pkg::addr_t mem_addr;
  matmul_pkg::row_t  mem_wdata;
  logic              mem_we;

  matmul_pkg::row_t  mem [DEPTH];
  matmul_pkg::row_t  rd_q;

  // Host request stage, one cycle ahead of the memory
  always_ff @(posedge clk) begin
    if (reset) begin
      host_sel_q <= 1'b0;
      host_we_q  <= 1'b0;
    end else begin
      host_sel_q <= host_sel;
      host_we_q  <= host_we;
    end
  end

  always_ff @(posedge clk) begin
    host_addr_q  <= host_addr;
    host_wdata_q <= host_wdata;
  end

  // Registered host request wins over the engine
  assign mem_addr  = host_sel_q ? host_addr_q  : eng.addr;
  assign mem_wdata = host_sel_q ? host_wdata_q : eng.wdata;
  assign mem_we    = host_sel_q ? host_we_q    : eng.we;

  // Single port, synchronous read, read-before-write
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    rd_q <= mem[mem_addr];
  end

  assign eng.rdata  = rd_q;
  assign host_rdata = rd_q;

endmodule

// File: rtl/mem_port_if.sv
interface mem_port_if;

  matmul_pkg::addr_t addr;
  matmul_pkg::row_t  wdata;
  logic              we;
  matmul_pkg::row_t  rdata;

  // Sequencer side
  modport engine (
    output addr, wdata, we,
    input  rdata
  );

  // Memory side
  modport buffer (
    input  addr, wdata, we,
    output rdata
  );

endinterface

// File: rtl/matmul_pkg.sv
package matmul_pkg;

  // Element and memory geometry
  localparam int DWIDTH     = 16;
  localparam int AWIDTH     = 7;
  localparam int MEM_DEPTH  = 128;
  localparam int ARRAY_SIZE = 4;

  // One matrix element, arithmetic wraps at this width
  typedef logic [DWIDTH-1:0] elem_t;

  // One memory word with one element per lane
  // Lane 0 sits in the low bits
  typedef elem_t [ARRAY_SIZE-1:0] row_t;

  // Memory address, also carries the inner dimension minus one
  typedef logic [AWIDTH-1:0] addr_t;

endpackage
